// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_hamming_codec
FILELIST  := hamming_codec.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -F -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/hamming_codec_top.sv
// Hamming (7,4) codec peripheral, top level
// Host register block wired to the encoder and decoder it steers
`timescale 1ns/10ps

module hamming_codec_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  hamming_regmap_pkg::addr_t     address,
    input  logic                          data_write,
    input  hamming_regmap_pkg::bus_data_t data_in,
    output hamming_regmap_pkg::bus_data_t data_out
);
    import hamming_types_pkg::*;

    nibble_t   enc_data;       // Nibble to encode
    codeword_t enc_codeword;   // Its codeword
    codeword_t dec_word;       // Word to check
    nibble_t   dec_data;       // Corrected nibble
    syndrome_t dec_syndrome;
    logic      dec_corrected;  // A bit was flipped

    hamming_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .address       (address),
        .data_write    (data_write),
        .data_in       (data_in),
        .data_out      (data_out),
        .enc_data      (enc_data),
        .enc_codeword  (enc_codeword),
        .dec_word      (dec_word),
        .dec_data      (dec_data),
        .dec_syndrome  (dec_syndrome),
        .dec_corrected (dec_corrected)
    );

    hamming_encoder u_encoder (
        .data     (enc_data),
        .codeword (enc_codeword)
    );

    hamming_decoder u_decoder (
        .clk       (clk),
        .word      (dec_word),
        .data      (dec_data),
        .syndrome  (dec_syndrome),
        .corrected (dec_corrected)
    );

endmodule

// File: design/hamming_decoder.sv
// Hamming (7,4) decoder
// Syndrome of the received word, single-bit correction, data extraction
// Combinational; clk only samples the built-in checks
`timescale 1ns/10ps

module hamming_decoder (
    input  logic                         clk,
    input  hamming_types_pkg::codeword_t word,
    output hamming_types_pkg::nibble_t   data,
    output hamming_types_pkg::syndrome_t syndrome,
    output logic                         corrected
);
    import hamming_types_pkg::*;

    codeword_t fixed;  // Word after the flip

    // Three even-parity checks, bit k of result covers positions with bit k set
    function automatic syndrome_t check_bits(input codeword_t w);
        syndrome_t s;
        s[0] = w[BIT_P0] ^ w[BIT_D0] ^ w[BIT_D1] ^ w[BIT_D3];  // 1,3,5,7
        s[1] = w[BIT_P1] ^ w[BIT_D0] ^ w[BIT_D2] ^ w[BIT_D3];  // 2,3,6,7
        s[2] = w[BIT_P2] ^ w[BIT_D1] ^ w[BIT_D2] ^ w[BIT_D3];  // 4,5,6,7
        return s;
    endfunction

    assign syndrome = check_bits(word);

    // Flip the bit at 1-indexed position syndrome, none when zero
    always_comb begin
        for (int i = 0; i < CODE_W; i++) begin
            fixed[i] = word[i] ^ (syndrome == syndrome_t'(i + 1));
        end
    end

    assign data      = {fixed[BIT_D3], fixed[BIT_D2], fixed[BIT_D1], fixed[BIT_D0]};
    assign corrected = (syndrome != SYNDROME_NONE);

    // Whatever came in, the repaired word must check clean
    a_fixed_clean: assert property (@(posedge clk) check_bits(fixed) == SYNDROME_NONE)
        else $error("decoder left word %h with syndrome %h", fixed, check_bits(fixed));

    // At most one bit touched, and only when an error was flagged
    a_single_flip: assert property (@(posedge clk)
        $countones(fixed ^ word) == (corrected ? 1 : 0))
        else $error("decoder flipped %0d bits of %h", $countones(fixed ^ word), word);

endmodule

// File: design/hamming_encoder.sv
// Hamming (7,4) encoder
// Three parity bits from the nibble, placed around the data bits
// Purely combinational
`timescale 1ns/10ps

module hamming_encoder (
    input  hamming_types_pkg::nibble_t   data,
    output hamming_types_pkg::codeword_t codeword
);
    import hamming_types_pkg::*;

    logic p0, p1, p2;

    assign p0 = data[0] ^ data[1] ^ data[3];  // Positions 1,3,5,7
    assign p1 = data[0] ^ data[2] ^ data[3];  // Positions 2,3,6,7
    assign p2 = data[1] ^ data[2] ^ data[3];  // Positions 4,5,6,7

    always_comb begin
        codeword         = '0;
        codeword[BIT_P0] = p0;
        codeword[BIT_P1] = p1;
        codeword[BIT_D0] = data[0];
        codeword[BIT_P2] = p2;
        codeword[BIT_D1] = data[1];
        codeword[BIT_D2] = data[2];
        codeword[BIT_D3] = data[3];
    end

endmodule

// File: design/hamming_regmap_pkg.sv
// Host register map of the Hamming codec peripheral
// Bus widths, the error counter type and the register addresses
package hamming_regmap_pkg;

    localparam int ADDR_W  = 4;
    localparam int BUS_W   = 8;
    localparam int COUNT_W = 8;

    typedef logic [ADDR_W-1:0]  addr_t;       // Register address
    typedef logic [BUS_W-1:0]   bus_data_t;   // Read and write data
    typedef logic [COUNT_W-1:0] err_count_t;  // Corrected error tally

    localparam err_count_t ERR_COUNT_MAX = '1;  // Counter sticks here

    // Register addresses
    localparam addr_t ADDR_ENC_IN    = 4'h0;  // R/W encoder input nibble
    localparam addr_t ADDR_ENCODED   = 4'h1;  // RO codeword
    localparam addr_t ADDR_RECEIVED  = 4'h2;  // RO word as received
    localparam addr_t ADDR_DEC_IN    = 4'h3;  // W word in, R decoded nibble
    localparam addr_t ADDR_SYNDROME  = 4'h4;  // RO syndrome
    localparam addr_t ADDR_ERR_COUNT = 4'h5;  // R count, any write clears

    // Addresses above this one are unmapped
    localparam addr_t ADDR_LAST = ADDR_ERR_COUNT;

endpackage

// File: design/hamming_regs.sv
// Register block of the Hamming codec peripheral
// Write decode, result capture, saturating error counter and read mux
// Results are captured on the write edge and readable the next cycle
`timescale 1ns/10ps

module hamming_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  hamming_regmap_pkg::addr_t     address,
    input  logic                          data_write,
    input  hamming_regmap_pkg::bus_data_t data_in,
    output hamming_regmap_pkg::bus_data_t data_out,
    output hamming_types_pkg::nibble_t    enc_data,
    input  hamming_types_pkg::codeword_t  enc_codeword,
    output hamming_types_pkg::codeword_t  dec_word,
    input  hamming_types_pkg::nibble_t    dec_data,
    input  hamming_types_pkg::syndrome_t  dec_syndrome,
    input  logic                          dec_corrected
);
    import hamming_types_pkg::*;
    import hamming_regmap_pkg::*;

    nibble_t    enc_in_q;     // Last nibble written to encoder
    codeword_t  encoded_q;    // Its codeword
    codeword_t  received_q;   // Last word written to decoder
    nibble_t    decoded_q;    // Corrected data of that word
    syndrome_t  syndrome_q;
    err_count_t err_count_q;  // Corrections since last clear

    logic wr_enc;
    logic wr_dec;
    logic wr_clr;

    // Codec blocks see the bus data directly
    assign enc_data = data_in[NIBBLE_W-1:0];
    assign dec_word = data_in[CODE_W-1:0];

    // Write decode, writes elsewhere fall on the floor
    assign wr_enc = data_write && (address == ADDR_ENC_IN);
    assign wr_dec = data_write && (address == ADDR_DEC_IN);
    assign wr_clr = data_write && (address == ADDR_ERR_COUNT);

    // Encoder side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enc_in_q  <= '0;
            encoded_q <= '0;
        end else if (wr_enc) begin
            enc_in_q  <= enc_data;
            encoded_q <= enc_codeword;  // Encoder result of this same write
        end
    end

    // Decoder side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            received_q <= '0;
            decoded_q  <= '0;
            syndrome_q <= '0;
        end else if (wr_dec) begin
            received_q <= dec_word;
            decoded_q  <= dec_data;
            syndrome_q <= dec_syndrome;
        end
    end

    // Error counter, clear has priority over a count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_count_q <= '0;
        end else if (wr_clr) begin
            err_count_q <= '0;
        end else if (wr_dec && dec_corrected && (err_count_q != ERR_COUNT_MAX)) begin
            err_count_q <= err_count_q + err_count_t'(1);  // Sticks at max
        end
    end

    // Read mux, narrower fields zero-extended
    always_comb begin
        case (address)
            ADDR_ENC_IN:    data_out = bus_data_t'(enc_in_q);
            ADDR_ENCODED:   data_out = bus_data_t'(encoded_q);
            ADDR_RECEIVED:  data_out = bus_data_t'(received_q);
            ADDR_DEC_IN:    data_out = bus_data_t'(decoded_q);
            ADDR_SYNDROME:  data_out = bus_data_t'(syndrome_q);
            ADDR_ERR_COUNT: data_out = bus_data_t'(err_count_q);
            default:        data_out = '0;  // Unmapped
        endcase
    end

    // Full counter only leaves 255 through a clear
    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (err_count_q == ERR_COUNT_MAX) && !wr_clr |=> (err_count_q == ERR_COUNT_MAX))
        else $error("error counter left saturation without a clear");

endmodule

// File: design/hamming_types_pkg.sv
// Hamming (7,4) code definitions
// Data, codeword and syndrome types plus the bit layout of a codeword
// Layout is {d3,d2,d1,p2,d0,p1,p0}, bit i holds 1-indexed position i+1
package hamming_types_pkg;

    localparam int NIBBLE_W = 4;  // Data bits per word
    localparam int CODE_W   = 7;  // Data plus parity
    localparam int SYN_W    = 3;  // Enough to name any of 7 positions

    typedef logic [NIBBLE_W-1:0] nibble_t;    // {d3,d2,d1,d0}
    typedef logic [CODE_W-1:0]   codeword_t;  // {d3,d2,d1,p2,d0,p1,p0}
    typedef logic [SYN_W-1:0]    syndrome_t;  // 0 or failing position

    localparam syndrome_t SYNDROME_NONE = '0;  // Word checks clean

    // Bit index of each field within a codeword
    localparam int BIT_P0 = 0;  // Position 1
    localparam int BIT_P1 = 1;  // Position 2
    localparam int BIT_D0 = 2;  // Position 3
    localparam int BIT_P2 = 3;  // Position 4
    localparam int BIT_D1 = 4;  // Position 5
    localparam int BIT_D2 = 5;  // Position 6
    localparam int BIT_D3 = 6;  // Position 7

endpackage

// File: hamming_codec.f
design/hamming_types_pkg.sv
design/hamming_regmap_pkg.sv
design/hamming_encoder.sv
design/hamming_decoder.sv
design/hamming_regs.sv
design/hamming_codec_top.sv
tb/tb_hamming_codec.sv

// File: tb/tb_hamming_codec.sv
// Testbench for the Hamming (7,4) codec peripheral
// Drives the host bus, models the code from the position rules and checks each read
`timescale 1ns/10ps

module tb_hamming_codec;
    import hamming_types_pkg::*;
    import hamming_regmap_pkg::*;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 2;
    localparam int N_RANDOM     = 300;  // Single-error words in the saturation test

    // Bus cycles of every test in run order, one cycle per read or write
    localparam int BUS_CYCLES = RESET_CYCLES
                              + 16                                           // Reset state
                              + 16 * 3                                       // Encoding
                              + 1 + 16 * 5                                   // Clean decoding
                              + 112 * 3 + 1                                  // Correction
                              + 2 + N_RANDOM + N_RANDOM / 4 + 1 + 1 + 4 + 1  // Counter
                              + 13 + 6 + 10;                                 // Ignored writes

    logic      clk;
    logic      rst_n;
    addr_t     address;
    logic      data_write;
    bus_data_t data_in;
    bus_data_t data_out;

    nibble_t   exp_enc_in;    // Last nibble sent to the encoder
    codeword_t exp_received;  // Last word sent to the decoder
    int        model_count;   // Saturating model of the error counter

    int    seed = 32'hbc0a_b6c1;
    int    errors;
    int    test_errors;
    int    num_checks;
    int    tests_run;
    int    tests_failed;
    string test_name;

    hamming_codec_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data_write (data_write),
        .data_in    (data_in),
        .data_out   (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Watchdog, twice the bus cycles the tests need
    initial begin
        #(BUS_CYCLES * PERIOD * 2);
        $display("Timeout: the tests did not finish within %0d clock cycles", BUS_CYCLES * 2);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Positions covered by parity check k, those whose 1-indexed number has bit k set
    function automatic codeword_t check_mask(input int k);
        codeword_t m;
        m = '0;
        for (int pos = 1; pos <= 7; pos++) begin
            if (((pos >> k) & 1) == 1)
                m = m | (codeword_t'(1) << (pos - 1));
        end
        return m;
    endfunction

    // Data at positions 3,5,6,7, parity at 1,2,4 makes each check even
    function automatic codeword_t ref_encode(input nibble_t d);
        codeword_t w;
        logic      par;
        w = {d[3], d[2], d[1], 1'b0, d[0], 2'b00};
        for (int k = 0; k < 3; k++) begin
            par = ^(w & check_mask(k));
            w   = w | (codeword_t'(par) << ((1 << k) - 1));
        end
        return w;
    endfunction

    function automatic syndrome_t ref_syndrome(input codeword_t w);
        syndrome_t s;
        s = '0;
        for (int k = 0; k < 3; k++)
            s = s | (syndrome_t'(^(w & check_mask(k))) << k);
        return s;
    endfunction

    function automatic nibble_t ref_decode(input codeword_t w);
        syndrome_t s;
        codeword_t f;
        s = ref_syndrome(w);
        f = w;
        if (s != SYNDROME_NONE)
            f = f ^ (codeword_t'(1) << (s - 1));  // Syndrome names the bad position
        return {f[6], f[5], f[4], f[2]};
    endfunction

    function automatic nibble_t random_nibble();
        return nibble_t'($random(seed));
    endfunction

    function automatic int random_bit_index();
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % 7;
    endfunction

    // Bus access, entered and left 5 ns after a rising edge
    task automatic write_reg(input addr_t a, input bus_data_t d);
        address    = a;
        data_in    = d;
        data_write = 1'b1;
        @(posedge clk);  // Write lands here
        #5;
        data_write = 1'b0;
    endtask

    task automatic read_reg(input addr_t a, output bus_data_t value);
        address    = a;
        data_write = 1'b0;
        @(negedge clk);  // Read mux settled
        value = data_out;
        @(posedge clk);
        #5;
    endtask

    task automatic encode_write(input nibble_t n);
        write_reg(ADDR_ENC_IN, bus_data_t'(n));
        exp_enc_in = n;
    endtask

    task automatic decode_write(input codeword_t w);
        write_reg(ADDR_DEC_IN, bus_data_t'(w));
        exp_received = w;
        if (ref_syndrome(w) != SYNDROME_NONE && model_count < 255)
            model_count++;
    endtask

    task automatic report_mismatch(input string what, input int exp, input bus_data_t got);
        $display("FAIL %s: expected %h, got %h at %0t", what, exp, got, $time);
        errors++;
        test_errors++;
    endtask

    task automatic check_nibble(input string what, input nibble_t exp, input bus_data_t got);
        num_checks++;
        if (got !== bus_data_t'(exp)) report_mismatch(what, int'(exp), got);
    endtask

    task automatic check_codeword(input string what, input codeword_t exp, input bus_data_t got);
        num_checks++;
        if (got !== bus_data_t'(exp)) report_mismatch(what, int'(exp), got);
    endtask

    task automatic check_syndrome(input string what, input syndrome_t exp, input bus_data_t got);
        num_checks++;
        if (got !== bus_data_t'(exp)) report_mismatch(what, int'(exp), got);
    endtask

    task automatic check_count(input string what, input err_count_t exp, input bus_data_t got);
        num_checks++;
        if (got !== bus_data_t'(exp)) report_mismatch(what, int'(exp), got);
    endtask

    task automatic check_bus(input string what, input bus_data_t exp, input bus_data_t got);
        num_checks++;
        if (got !== exp) report_mismatch(what, int'(exp), got);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("%s: %0d mismatches", test_name, test_errors);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    // All six mapped registers against the model
    task automatic check_regs();
        bus_data_t got;
        read_reg(ADDR_ENC_IN, got);
        check_nibble("enc_in", exp_enc_in, got);
        read_reg(ADDR_ENCODED, got);
        check_codeword("encoded", ref_encode(exp_enc_in), got);
        read_reg(ADDR_RECEIVED, got);
        check_codeword("received", exp_received, got);
        read_reg(ADDR_DEC_IN, got);
        check_nibble("decoded", ref_decode(exp_received), got);
        read_reg(ADDR_SYNDROME, got);
        check_syndrome("syndrome", ref_syndrome(exp_received), got);
        read_reg(ADDR_ERR_COUNT, got);
        check_count("err_count", err_count_t'(model_count), got);
    endtask

    task automatic test_reset_state();
        bus_data_t got;
        begin_test("reset state");
        for (int a = 0; a < 16; a++) begin
            read_reg(addr_t'(a), got);
            check_bus($sformatf("data_out[%0d]", a), '0, got);
        end
        end_test();
    endtask

    task automatic test_encoding();
        bus_data_t got;
        begin_test("encoding");
        for (int n = 0; n < 16; n++) begin
            encode_write(nibble_t'(n));
            read_reg(ADDR_ENC_IN, got);
            check_nibble("enc_in", nibble_t'(n), got);
            read_reg(ADDR_ENCODED, got);
            check_codeword("encoded", ref_encode(nibble_t'(n)), got);
        end
        end_test();
    endtask

    task automatic test_clean_decode();
        bus_data_t got;
        codeword_t w;
        begin_test("clean decoding");
        read_reg(ADDR_ERR_COUNT, got);
        check_count("err_count", err_count_t'(model_count), got);
        for (int n = 0; n < 16; n++) begin
            w = ref_encode(nibble_t'(n));
            decode_write(w);
            read_reg(ADDR_RECEIVED, got);
            check_codeword("received", w, got);
            read_reg(ADDR_DEC_IN, got);
            check_nibble("decoded", nibble_t'(n), got);
            read_reg(ADDR_SYNDROME, got);
            check_syndrome("syndrome", SYNDROME_NONE, got);
            read_reg(ADDR_ERR_COUNT, got);
            check_count("err_count", err_count_t'(model_count), got);  // No change
        end
        end_test();
    endtask

    task automatic test_correction();
        bus_data_t got;
        begin_test("single-bit correction");
        for (int n = 0; n < 16; n++) begin
            for (int b = 0; b < 7; b++) begin
                decode_write(ref_encode(nibble_t'(n)) ^ (codeword_t'(1) << b));
                read_reg(ADDR_DEC_IN, got);
                check_nibble("decoded", nibble_t'(n), got);
                read_reg(ADDR_SYNDROME, got);
                check_syndrome("syndrome", syndrome_t'(b + 1), got);  // 1-indexed position
            end
        end
        read_reg(ADDR_ERR_COUNT, got);
        check_count("err_count", err_count_t'(112), got);
        end_test();
    endtask

    task automatic test_counter();
        bus_data_t got;
        begin_test("counter clear and saturation");
        write_reg(ADDR_ERR_COUNT, bus_data_t'($random(seed)));  // Any value clears
        model_count = 0;
        read_reg(ADDR_ERR_COUNT, got);
        check_count("err_count", err_count_t'(0), got);
        for (int i = 0; i < N_RANDOM; i++) begin
            decode_write(ref_encode(random_nibble()) ^ (codeword_t'(1) << random_bit_index()));
            if (i % 4 == 3)
                decode_write(ref_encode(random_nibble()));  // Clean word in between
            if (i == N_RANDOM / 3) begin
                read_reg(ADDR_ERR_COUNT, got);
                check_count("err_count", err_count_t'(model_count), got);  // Below saturation
            end
        end
        read_reg(ADDR_ERR_COUNT, got);
        check_count("err_count", err_count_t'(255), got);
        for (int i = 0; i < 4; i++)
            decode_write(ref_encode(random_nibble()));
        read_reg(ADDR_ERR_COUNT, got);
        check_count("err_count", err_count_t'(255), got);  // Still saturated
        end_test();
    endtask

    task automatic test_ignored_writes();
        bus_data_t got;
        begin_test("ignored writes and unmapped reads");
        for (int a = 0; a < 16; a++) begin
            if (a != 0 && a != 3 && a != 5)
                write_reg(addr_t'(a), bus_data_t'($random(seed)));
        end
        check_regs();
        for (int a = 6; a < 16; a++) begin
            read_reg(addr_t'(a), got);
            check_bus($sformatf("data_out[%0d]", a), '0, got);
        end
        end_test();
    endtask

    initial begin
        rst_n        = 1'b0;
        address      = '0;
        data_write   = 1'b0;
        data_in      = '0;
        exp_enc_in   = '0;
        exp_received = '0;
        model_count  = 0;
        errors       = 0;
        test_errors  = 0;
        num_checks   = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst_n = 1'b1;

        test_reset_state();
        test_encoding();
        test_clean_decode();
        test_correction();
        test_counter();
        test_ignored_writes();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, num_checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
